// ==== sp_top.f ====
src/sp_data_pkg.sv
src/sp_ctrl_pkg.sv
src/sp_ctrl.sv
src/sp_step_counter.sv
src/sample_buffer.sv
src/gray_decoder.sv
src/moving_average.sv
src/odd_even_sorter.sv
src/result_serializer.sv
src/sp_top.sv
tb/sp_clk_gen.sv
tb/sp_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = sp_tb
FILELIST  = sp_top.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Simulation finished: FAIL

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb/sp_tb.sv ====
`timescale 1ns/10ps

module sp_tb;

	localparam int NUM_SAMPLES    = sp_data_pkg::NUM_SAMPLES;
	localparam int MAG_W          = sp_data_pkg::SAMPLE_W - 1;
	localparam int NUM_FRAMES     = 24;
	// 25 busy cycles per frame at most, plus the widest idle gap
	localparam int FRAME_CYCLES   = 32;
	localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_CYCLES + 100;

	logic                     clk;
	logic                     rst_n;
	logic                     in_valid;
	sp_data_pkg::sample_t     in_data;
	sp_ctrl_pkg::mode_t       in_mode;
	logic                     out_valid;
	sp_data_pkg::out_sample_t out_data;

	integer seed;
	int     mismatch_cnt;
	int     other_err_cnt;
	int     cycle_cnt;

	// raw samples of the frame being driven
	sp_data_pkg::sample_t raw_v [NUM_SAMPLES];

	// expected beats in output order, with their test names
	sp_data_pkg::out_sample_t exp_q[$];
	string                    name_q[$];

	// beat currently on the bus
	sp_data_pkg::out_sample_t exp_head;
	string                    exp_name;
	logic                     exp_ok;
	int                       run_len;
	int                       last_run;

	sp_clk_gen u_clk_gen (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	sp_top dut_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid_i  (in_valid),
		.in_data_i   (in_data),
		.in_mode_i   (in_mode),
		.out_valid_o (out_valid),
		.out_data_o  (out_data)
	);

	// sign bit, then gray magnitude; binary bit b is the xor of gray bits b and up
	function automatic int gray_to_int(input sp_data_pkg::sample_t raw);
		logic [MAG_W-1:0] mag;
		int               val;
		for (int b = 0; b < MAG_W; b++) begin
			mag[b] = ^(raw[MAG_W-1:0] >> b);
		end
		val = int'(mag);
		return raw[MAG_W] ? -val : val;
	endfunction

	function automatic string mode_name(input sp_ctrl_pkg::mode_t mode);
		if (mode.gray_en && mode.avg_en) begin
			return "gray_avg";
		end else if (mode.gray_en) begin
			return "gray";
		end else if (mode.avg_en) begin
			return "avg";
		end
		return "raw";
	endfunction

	// decode, average, sort, then queue max, median and min
	task automatic build_expected(input sp_ctrl_pkg::mode_t mode, input string name);
		int work [NUM_SAMPLES];
		int tmp  [NUM_SAMPLES];
		int key;
		int j;
		for (int i = 0; i < NUM_SAMPLES; i++) begin
			if (mode.gray_en) begin
				work[i] = gray_to_int(raw_v[i]);
			end else begin
				work[i] = int'(raw_v[i]);
			end
		end
		if (mode.avg_en) begin
			for (int i = 0; i < NUM_SAMPLES; i++) begin
				tmp[i] = (work[(i + NUM_SAMPLES - 1) % NUM_SAMPLES] + work[i]
					+ work[(i + 1) % NUM_SAMPLES]) / 3;
			end
			work = tmp;
		end
		for (int i = 1; i < NUM_SAMPLES; i++) begin
			key = work[i];
			j   = i - 1;
			while (j >= 0 && work[j] > key) begin
				work[j+1] = work[j];
				j--;
			end
			work[j+1] = key;
		end
		exp_q.push_back(sp_data_pkg::out_sample_t'(work[NUM_SAMPLES-1]));
		exp_q.push_back(sp_data_pkg::out_sample_t'(work[NUM_SAMPLES/2]));
		exp_q.push_back(sp_data_pkg::out_sample_t'(work[0]));
		repeat (3) name_q.push_back(name);
	endtask

	// called on a falling edge, returns on the falling edge after the last sample
	task automatic drive_frame(input sp_ctrl_pkg::mode_t mode);
		for (int i = 0; i < NUM_SAMPLES; i++) begin
			raw_v[i] = sp_data_pkg::sample_t'($random(seed));
		end
		build_expected(mode, mode_name(mode));
		for (int i = 0; i < NUM_SAMPLES; i++) begin
			in_valid = 1'b1;
			in_data  = raw_v[i];
			// mode only counts on the first beat
			if (i == 0) begin
				in_mode = mode;
			end else begin
				in_mode = 2'($random(seed));
			end
			@(negedge clk);
		end
		in_valid = 1'b0;
		in_data  = '0;
		in_mode  = '0;
	endtask

	// returns on the first falling edge after the last beat
	task automatic wait_frame_done();
		while (!out_valid) @(negedge clk);
		while (out_valid) @(negedge clk);
	endtask

	task automatic finish_run();
		leftover_a: assert (exp_q.size() == 0)
			else begin
				other_err_cnt++;
				$display("%0d expected output beats never appeared", exp_q.size());
			end
		$display("checks done: %0d mismatches, %0d other errors", mismatch_cnt, other_err_cnt);
		if (mismatch_cnt == 0 && other_err_cnt == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	endtask

	always @(negedge clk) begin
		if (out_valid) begin
			run_len = run_len + 1;
			if (exp_q.size() > 0) begin
				exp_head = exp_q.pop_front();
				exp_name = name_q.pop_front();
				exp_ok   = 1'b1;
			end else begin
				exp_ok = 1'b0;
			end
		end else begin
			if (run_len != 0) begin
				last_run = run_len;
			end
			run_len = 0;
			exp_ok  = 1'b0;
		end
	end

	beat_expected_a: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> exp_ok)
		else begin
			other_err_cnt++;
			$display("output beat at %0t with no result pending", $time);
		end

	beat_value_a: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && exp_ok |-> out_data == exp_head)
		else begin
			mismatch_cnt++;
			$display("Mismatch in %s: expected %0d, actual %0d",
				exp_name, exp_head, $sampled(out_data));
		end

	idle_zero_a: assert property (@(posedge clk) disable iff (!rst_n)
		!out_valid |-> out_data == '0)
		else begin
			other_err_cnt++;
			$display("output data is %0d while out_valid is low", $sampled(out_data));
		end

	burst_len_a: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> run_len <= sp_ctrl_pkg::OUT_BEATS)
		else begin
			other_err_cnt++;
			$display("out_valid held high for more than three cycles");
		end

	burst_end_a: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(out_valid) |-> last_run == sp_ctrl_pkg::OUT_BEATS)
		else begin
			other_err_cnt++;
			$display("output burst of %0d beats instead of three", last_run);
		end

	initial begin
		sp_ctrl_pkg::mode_t mode;
		int                 gap;
		seed          = 32'he95d_dd4f;
		in_valid      = 1'b0;
		in_data       = '0;
		in_mode       = '0;
		mismatch_cnt  = 0;
		other_err_cnt = 0;
		exp_ok        = 1'b0;
		exp_head      = '0;
		exp_name      = "";
		run_len       = 0;
		last_run      = 0;
		while (rst_n !== 1'b1) @(negedge clk);
		// quiet stretch after reset
		repeat (4) @(negedge clk);
		for (int f = 0; f < NUM_FRAMES; f++) begin
			mode.gray_en = (f % 4) >= 2;
			mode.avg_en  = (f % 2) == 1;
			drive_frame(mode);
			wait_frame_done();
			// even groups of four run back to back, odd groups leave a gap
			gap = ((f / 4) % 2 == 1) ? 1 + int'(2'($random(seed))) : 0;
			repeat (gap) @(negedge clk);
		end
		repeat (4) @(negedge clk);
		finish_run();
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_cnt++;
		end
		other_err_cnt++;
		$display("timeout after %0d cycles, %0d beats still pending", cycle_cnt, exp_q.size());
		finish_run();
	end

endmodule

// ==== tb/sp_clk_gen.sv ====
`timescale 1ns/10ps

module sp_clk_gen (
	output logic clk_o,
	output logic rst_n_o
);
	initial begin
		clk_o = 1'b0;
		forever #5 clk_o = ~clk_o;
	end

	// release on a falling edge after three rising edges
	initial begin
		rst_n_o = 1'b0;
		repeat (3) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o = 1'b1;
	end

endmodule

// ==== src/sp_top.sv ====
`timescale 1ns/10ps

module sp_top (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     in_valid_i,
	input  sp_data_pkg::sample_t     in_data_i,
	input  sp_ctrl_pkg::mode_t       in_mode_i,
	output logic                     out_valid_o,
	output sp_data_pkg::out_sample_t out_data_o
);
	logic                 cnt_clr;
	logic                 cnt_inc;
	logic                 cnt_last;
	sp_ctrl_pkg::phase_e  phase;
	sp_ctrl_pkg::cnt_t    count;
	sp_ctrl_pkg::wb_sel_e wb_sel;
	logic                 sort_load;
	logic                 sort_step;
	logic                 cap;
	logic                 shift;
	sp_data_pkg::frame_t  frame;
	sp_data_pkg::frame_t  gray_frame;
	sp_data_pkg::frame_t  avg_frame;
	sp_data_pkg::stats_t  stats;

	sp_ctrl u_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid_i  (in_valid_i),
		.in_mode_i   (in_mode_i),
		.last_i      (cnt_last),
		.cnt_clr_o   (cnt_clr),
		.cnt_inc_o   (cnt_inc),
		.phase_o     (phase),
		.wb_sel_o    (wb_sel),
		.sort_load_o (sort_load),
		.sort_step_o (sort_step),
		.cap_o       (cap),
		.shift_o     (shift),
		.out_valid_o (out_valid_o)
	);

	sp_step_counter u_cnt (
		.clk     (clk),
		.rst_n   (rst_n),
		.clr_i   (cnt_clr),
		.inc_i   (cnt_inc),
		.phase_i (phase),
		.count_o (count),
		.last_o  (cnt_last)
	);

	// load beats write at the step count
	sample_buffer u_buf (
		.clk       (clk),
		.rst_n     (rst_n),
		.wb_sel_i  (wb_sel),
		.idx_i     (count),
		.in_data_i (in_data_i),
		.gray_i    (gray_frame),
		.avg_i     (avg_frame),
		.frame_o   (frame)
	);

	gray_decoder u_gray (
		.frame_i (frame),
		.frame_o (gray_frame)
	);

	moving_average u_avg (
		.frame_i (frame),
		.frame_o (avg_frame)
	);

	odd_even_sorter u_sort (
		.clk     (clk),
		.rst_n   (rst_n),
		.load_i  (sort_load),
		.step_i  (sort_step),
		.frame_i (frame),
		.stats_o (stats)
	);

	result_serializer u_ser (
		.clk     (clk),
		.rst_n   (rst_n),
		.cap_i   (cap),
		.shift_i (shift),
		.stats_i (stats),
		.data_o  (out_data_o)
	);

endmodule

// ==== src/result_serializer.sv ====
`timescale 1ns/10ps

module result_serializer (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     cap_i,
	input  logic                     shift_i,
	input  sp_data_pkg::stats_t      stats_i,
	output sp_data_pkg::out_sample_t data_o
);
	sp_data_pkg::stats_t sreg_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sreg_q <= '0;
		end else if (cap_i) begin
			sreg_q <= stats_i;
		end else if (shift_i) begin
			// move next result into the head slot
			sreg_q <= '{
				max: sreg_q.med,
				med: sreg_q.min,
				min: '0
			};
		end
	end

	// head is sign extended, zero between beats
	assign data_o = shift_i ? sp_data_pkg::out_sample_t'(sreg_q.max) : '0;

endmodule

// ==== src/odd_even_sorter.sv ====
`timescale 1ns/10ps

module odd_even_sorter (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                load_i,
	input  logic                step_i,
	input  sp_data_pkg::frame_t frame_i,
	output sp_data_pkg::stats_t stats_o
);
	sp_data_pkg::frame_t v_q;
	sp_data_pkg::frame_t v_d;
	// 0 swaps pairs starting at even slots
	logic                parity_q;

	always_comb begin
		v_d = v_q;
		for (int i = 0; i < sp_data_pkg::NUM_SAMPLES - 1; i++) begin
			if ((i % 2) == int'(parity_q) && v_q[i] > v_q[i+1]) begin
				v_d[i]   = v_q[i+1];
				v_d[i+1] = v_q[i];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load_i) begin
			v_q <= frame_i;
		end else if (step_i) begin
			v_q <= v_d;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			parity_q <= 1'b0;
		end else if (load_i) begin
			parity_q <= 1'b0;
		end else if (step_i) begin
			parity_q <= ~parity_q;
		end
	end

	// ascending order, smallest in slot 0
	assign stats_o = '{
		max: v_q[sp_data_pkg::NUM_SAMPLES-1],
		med: v_q[sp_data_pkg::NUM_SAMPLES/2],
		min: v_q[0]
	};

	load_step_excl_a: assert property (@(posedge clk) disable iff (!rst_n)
		!(load_i && step_i))
		else $error("sorter load and step together");

endmodule

// ==== src/moving_average.sv ====
`timescale 1ns/10ps

module moving_average (
	input  sp_data_pkg::frame_t frame_i,
	output sp_data_pkg::frame_t frame_o
);
	// three samples need two extra bits
	typedef logic signed [sp_data_pkg::SAMPLE_W+1:0] sum_t;

	sum_t sum [sp_data_pkg::NUM_SAMPLES];

	always_comb begin
		for (int i = 0; i < sp_data_pkg::NUM_SAMPLES; i++) begin
			// neighbours wrap around the frame
			sum[i] = sum_t'(frame_i[(i + sp_data_pkg::NUM_SAMPLES - 1) % sp_data_pkg::NUM_SAMPLES])
				+ sum_t'(frame_i[i])
				+ sum_t'(frame_i[(i + 1) % sp_data_pkg::NUM_SAMPLES]);
			// signed divide truncates toward zero
			frame_o[i] = sp_data_pkg::sample_t'(sum[i] / sum_t'(3));
		end
	end

endmodule

// ==== src/gray_decoder.sv ====
`timescale 1ns/10ps

module gray_decoder (
	input  sp_data_pkg::frame_t frame_i,
	output sp_data_pkg::frame_t frame_o
);
	// sign bit on top, gray magnitude below
	function automatic sp_data_pkg::sample_t decode(input sp_data_pkg::sample_t g);
		logic [sp_data_pkg::SAMPLE_W-2:0] mag;
		sp_data_pkg::sample_t             val;
		mag[sp_data_pkg::SAMPLE_W-2] = g[sp_data_pkg::SAMPLE_W-2];
		for (int b = sp_data_pkg::SAMPLE_W - 3; b >= 0; b--) begin
			mag[b] = mag[b+1] ^ g[b];
		end
		val = {1'b0, mag};
		return g[sp_data_pkg::SAMPLE_W-1] ? -val : val;
	endfunction

	always_comb begin
		for (int s = 0; s < sp_data_pkg::NUM_SAMPLES; s++) begin
			frame_o[s] = decode(frame_i[s]);
		end
	end

endmodule

// ==== src/sample_buffer.sv ====
`timescale 1ns/10ps

module sample_buffer (
	input  logic                  clk,
	input  logic                  rst_n,
	input  sp_ctrl_pkg::wb_sel_e  wb_sel_i,
	input  sp_ctrl_pkg::cnt_t     idx_i,
	input  sp_data_pkg::sample_t  in_data_i,
	input  sp_data_pkg::frame_t   gray_i,
	input  sp_data_pkg::frame_t   avg_i,
	output sp_data_pkg::frame_t   frame_o
);
	sp_data_pkg::frame_t frame_q;

	always_ff @(posedge clk) begin
		case (wb_sel_i)
			// one sample per load beat
			sp_ctrl_pkg::WB_IN: begin
				frame_q[idx_i] <= in_data_i;
			end
			sp_ctrl_pkg::WB_GRAY: begin
				frame_q <= gray_i;
			end
			sp_ctrl_pkg::WB_AVG: begin
				frame_q <= avg_i;
			end
			default: begin
			end
		endcase
	end

	assign frame_o = frame_q;

	load_idx_range_a: assert property (@(posedge clk) disable iff (!rst_n)
		wb_sel_i == sp_ctrl_pkg::WB_IN |-> idx_i < sp_data_pkg::NUM_SAMPLES)
		else $error("load index %0d out of frame", idx_i);

endmodule

// ==== src/sp_step_counter.sv ====
`timescale 1ns/10ps

module sp_step_counter (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                clr_i,
	input  logic                inc_i,
	input  sp_ctrl_pkg::phase_e phase_i,
	output sp_ctrl_pkg::cnt_t   count_o,
	output logic                last_o
);
	sp_ctrl_pkg::cnt_t limit;

	always_comb begin
		case (phase_i)
			sp_ctrl_pkg::SORT_PH: limit = sp_ctrl_pkg::cnt_t'(sp_ctrl_pkg::SORT_PASSES - 1);
			sp_ctrl_pkg::OUT_PH:  limit = sp_ctrl_pkg::cnt_t'(sp_ctrl_pkg::OUT_BEATS - 1);
			default:              limit = sp_ctrl_pkg::cnt_t'(sp_data_pkg::NUM_SAMPLES - 1);
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count_o <= '0;
		end else if (clr_i) begin
			count_o <= '0;
		end else if (inc_i) begin
			count_o <= count_o + 1'b1;
		end
	end

	assign last_o = (count_o == limit);

	// controller must clear before a phase change
	count_in_range_a: assert property (@(posedge clk) disable iff (!rst_n)
		count_o <= limit)
		else $error("step count %0d above limit %0d", count_o, limit);

endmodule

// ==== src/sp_ctrl.sv ====
`timescale 1ns/10ps

module sp_ctrl (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   in_valid_i,
	input  sp_ctrl_pkg::mode_t     in_mode_i,
	input  logic                   last_i,
	output logic                   cnt_clr_o,
	output logic                   cnt_inc_o,
	output sp_ctrl_pkg::phase_e    phase_o,
	output sp_ctrl_pkg::wb_sel_e   wb_sel_o,
	output logic                   sort_load_o,
	output logic                   sort_step_o,
	output logic                   cap_o,
	output logic                   shift_o,
	output logic                   out_valid_o
);
	sp_ctrl_pkg::sp_state_e state_q;
	sp_ctrl_pkg::sp_state_e state_d;
	sp_ctrl_pkg::mode_t     mode_q;
	// set once the serializer holds the results
	logic                   armed_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= sp_ctrl_pkg::IDLE;
			mode_q  <= '0;
			armed_q <= 1'b0;
		end else begin
			state_q <= state_d;
			armed_q <= (state_q == sp_ctrl_pkg::OUT) && (state_d == sp_ctrl_pkg::OUT);
			if (state_q == sp_ctrl_pkg::IDLE && in_valid_i) begin
				mode_q <= in_mode_i;
			end
		end
	end

	always_comb begin
		state_d     = state_q;
		cnt_clr_o   = 1'b0;
		cnt_inc_o   = 1'b0;
		phase_o     = sp_ctrl_pkg::LOAD_PH;
		wb_sel_o    = sp_ctrl_pkg::WB_NONE;
		sort_load_o = 1'b0;
		sort_step_o = 1'b0;
		cap_o       = 1'b0;
		shift_o     = 1'b0;
		out_valid_o = 1'b0;
		case (state_q)
			sp_ctrl_pkg::IDLE: begin
				// first sample goes to slot 0
				if (in_valid_i) begin
					wb_sel_o  = sp_ctrl_pkg::WB_IN;
					cnt_inc_o = 1'b1;
					state_d   = sp_ctrl_pkg::LOAD;
				end
			end
			sp_ctrl_pkg::LOAD: begin
				if (in_valid_i) begin
					wb_sel_o = sp_ctrl_pkg::WB_IN;
					if (last_i) begin
						cnt_clr_o = 1'b1;
						if (mode_q.gray_en) begin
							state_d = sp_ctrl_pkg::GRAY;
						end else if (mode_q.avg_en) begin
							state_d = sp_ctrl_pkg::AVG;
						end else begin
							state_d = sp_ctrl_pkg::SORT_LOAD;
						end
					end else begin
						cnt_inc_o = 1'b1;
					end
				end
			end
			sp_ctrl_pkg::GRAY: begin
				wb_sel_o = sp_ctrl_pkg::WB_GRAY;
				state_d  = mode_q.avg_en ? sp_ctrl_pkg::AVG : sp_ctrl_pkg::SORT_LOAD;
			end
			sp_ctrl_pkg::AVG: begin
				wb_sel_o = sp_ctrl_pkg::WB_AVG;
				state_d  = sp_ctrl_pkg::SORT_LOAD;
			end
			sp_ctrl_pkg::SORT_LOAD: begin
				sort_load_o = 1'b1;
				cnt_clr_o   = 1'b1;
				state_d     = sp_ctrl_pkg::SORT;
			end
			sp_ctrl_pkg::SORT: begin
				phase_o     = sp_ctrl_pkg::SORT_PH;
				sort_step_o = 1'b1;
				if (last_i) begin
					cnt_clr_o = 1'b1;
					state_d   = sp_ctrl_pkg::OUT;
				end else begin
					cnt_inc_o = 1'b1;
				end
			end
			sp_ctrl_pkg::OUT: begin
				phase_o = sp_ctrl_pkg::OUT_PH;
				if (!armed_q) begin
					cap_o = 1'b1;
				end else begin
					shift_o     = 1'b1;
					out_valid_o = 1'b1;
					if (last_i) begin
						cnt_clr_o = 1'b1;
						state_d   = sp_ctrl_pkg::IDLE;
					end else begin
						cnt_inc_o = 1'b1;
					end
				end
			end
			default: state_d = sp_ctrl_pkg::IDLE;
		endcase
	end

	// capture is followed by exactly three beats, then out_valid drops
	out_burst_a: assert property (@(posedge clk) disable iff (!rst_n)
		cap_o |=> out_valid_o ##1 out_valid_o ##1 out_valid_o ##1 !out_valid_o)
		else $error("output burst after capture is not three beats");

endmodule

// ==== src/sp_ctrl_pkg.sv ====
package sp_ctrl_pkg;

	localparam int SORT_PASSES = 9;
	localparam int OUT_BEATS   = 3;
	localparam int CNT_W       = 4;

	typedef logic [CNT_W-1:0] cnt_t;

	// captured with the first sample
	typedef struct packed {
		logic gray_en;
		logic avg_en;
	} mode_t;

	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		GRAY,
		AVG,
		SORT_LOAD,
		SORT,
		OUT
	} sp_state_e;

	// picks the counter limit
	typedef enum logic [1:0] {
		LOAD_PH,
		SORT_PH,
		OUT_PH
	} phase_e;

	// frame buffer write source
	typedef enum logic [1:0] {
		WB_NONE,
		WB_IN,
		WB_GRAY,
		WB_AVG
	} wb_sel_e;

endpackage

// ==== src/sp_data_pkg.sv ====
package sp_data_pkg;

	// frame geometry
	localparam int SAMPLE_W    = 9;
	localparam int NUM_SAMPLES = 9;

	// results leave one bit wider than the samples
	localparam int OUT_W       = 10;

	typedef logic signed [SAMPLE_W-1:0] sample_t;

	typedef logic signed [OUT_W-1:0] out_sample_t;

	// index 0 is the first sample of the frame
	typedef sample_t [NUM_SAMPLES-1:0] frame_t;

	// order of fields is also the output order
	typedef struct packed {
		sample_t max;
		sample_t med;
		sample_t min;
	} stats_t;

endpackage
